// ==== logic/acq_pkg.sv ====
// ========================================
// shared widths, register map and types for the acquisition path
// sample word layout matches what the host unpacks on read
// ========================================
`default_nettype none

package acq_pkg;

   // ========================================
   // widths
   // ========================================
   localparam int adc_w  = 14;
   localparam int dac_w  = 16;
   localparam int word_w = 32;

   // ========================================
   // host register map
   // ========================================
   localparam logic [7:0] addr_ctrl   = 8'h00;
   localparam logic [7:0] addr_adcmux = 8'h01;
   localparam logic [7:0] addr_thresh = 8'h02;
   localparam logic [7:0] addr_dac    = 8'h03;
   localparam logic [7:0] addr_trig   = 8'h40;   // trigger word, self clearing

   // bits in the control word
   localparam int ctrl_trig_en_bit  = 0;
   localparam int ctrl_soft_rst_bit = 2;
   localparam int ctrl_capture_bit  = 4;

   // bit in the trigger word
   localparam int trig_manual_bit = 1;

   // live configuration, fanned out to tagger and fifo
   typedef struct packed {
      logic             trig_en;
      logic             capture_en;
      logic             soft_rst;    // level, held until host clears it
      logic [adc_w-1:0] threshold;
      logic [dac_w-1:0] dac_value;
   } acq_cfg_t;

   // field view of one stored sample
   typedef struct packed {
      logic [dac_w-1:0] dac_value;   // 31..16
      logic [adc_w-1:0] sample;      // 15..2, restored bit order
      logic             trig_fall;   // 1
      logic             trig_rise;   // 0
   } sample_fields_t;

   // same 32 bits, raw for storage and readout, fields for packing
   typedef union packed {
      logic [word_w-1:0] raw;
      sample_fields_t    fields;
   } sample_word_u;

endpackage

`default_nettype wire

// ==== logic/acq_regs.sv ====
// ========================================
// host register block, single write strobe, no readback
// writes land on the next edge, unknown addresses dropped
// trigger word yields a one cycle manual_trig pulse
// ========================================
`timescale 1ns/1ns
`default_nettype none

module acq_regs
   import acq_pkg::*;
(
   input  logic              okClk,
   input  logic              rst,
   input  logic              reg_wr,
   input  logic [7:0]        reg_addr,
   input  logic [word_w-1:0] reg_wdata,
   output acq_cfg_t          cfg,
   output logic              manual_trig,
   output logic [1:0]        adc_mux
);

   // ========================================
   // control and data registers
   // ========================================
   always_ff @(posedge okClk) begin
      if (rst) begin
         cfg         <= '0;   // trig, capture and soft reset all off
         adc_mux     <= 2'd0;
         manual_trig <= 1'b0;
      end else begin
         manual_trig <= 1'b0;   // pulse only lasts one cycle
         if (reg_wr) begin
            case (reg_addr)
               addr_ctrl: begin
                  cfg.trig_en    <= reg_wdata[ctrl_trig_en_bit];
                  cfg.soft_rst   <= reg_wdata[ctrl_soft_rst_bit];
                  cfg.capture_en <= reg_wdata[ctrl_capture_bit];
               end
               addr_adcmux: begin
                  adc_mux <= reg_wdata[1:0];   // board mux pins
               end
               addr_thresh: begin
                  cfg.threshold <= reg_wdata[adc_w-1:0];
               end
               addr_dac: begin
                  // stands in for the serial dac, value only tags samples
                  cfg.dac_value <= reg_wdata[dac_w-1:0];
               end
               addr_trig: begin
                  manual_trig <= reg_wdata[trig_manual_bit];
               end
               default: begin
               end
            endcase
         end
      end
   end

endmodule

`default_nettype wire

// ==== logic/acq_top.sv ====
// ========================================
// acquisition path top, single okClk domain
// host side is a plain write strobe and a read strobe
// samples are never stalled, a full fifo only drops them
// ========================================
`timescale 1ns/1ns
`default_nettype none

module acq_top
   import acq_pkg::*;
#(
   parameter int DEPTH      = 16,
   parameter int BLOCK_SIZE = 8,
   parameter int FILL_LEVEL = 12
) (
   input  logic                   okClk,
   input  logic                   rst,
   // host register writes
   input  logic                   reg_wr,
   input  logic [7:0]             reg_addr,
   input  logic [word_w-1:0]      reg_wdata,
   // adc side
   input  logic                   adc_strobe,
   input  logic [adc_w-1:0]       adc_data,   // bit reversed
   // host readout
   input  logic                   rd_en,
   output logic [word_w-1:0]      rd_data,
   output logic                   rd_valid,
   // status
   output logic [1:0]             adc_mux,
   output logic [$clog2(DEPTH):0] fill_count,
   output logic                   overflow,
   output logic                   block_ready,
   output logic                   fill_trigger
);

   acq_cfg_t     cfg;
   logic         manual_trig;
   logic         word_wr;
   sample_word_u word;

   // ========================================
   // instances
   // ========================================
   acq_regs u_regs (
      .okClk       (okClk),
      .rst         (rst),
      .reg_wr      (reg_wr),
      .reg_addr    (reg_addr),
      .reg_wdata   (reg_wdata),
      .cfg         (cfg),
      .manual_trig (manual_trig),
      .adc_mux     (adc_mux)
   );

   sample_tagger u_tagger (
      .okClk       (okClk),
      .rst         (rst),
      .cfg         (cfg),
      .manual_trig (manual_trig),
      .adc_strobe  (adc_strobe),
      .adc_data    (adc_data),
      .word_wr     (word_wr),
      .word        (word)
   );

   sample_fifo #(.DEPTH(DEPTH)) u_fifo (
      .okClk    (okClk),
      .rst      (rst),
      .cfg      (cfg),
      .word_wr  (word_wr),
      .word     (word),
      .rd_en    (rd_en),
      .rd_data  (rd_data),
      .rd_valid (rd_valid),
      .count    (fill_count),
      .overflow (overflow)
   );

   block_throttle #(
      .DEPTH      (DEPTH),
      .BLOCK_SIZE (BLOCK_SIZE),
      .FILL_LEVEL (FILL_LEVEL)
   ) u_throttle (
      .okClk        (okClk),
      .rst          (rst),
      .count        (fill_count),   // same count the host sees
      .block_ready  (block_ready),
      .fill_trigger (fill_trigger)
   );

endmodule

`default_nettype wire

// ==== logic/block_throttle.sv ====
// ========================================
// block_ready and fill level trigger from the fifo count
// both outputs lag count by one cycle
// ========================================
`timescale 1ns/1ns
`default_nettype none

module block_throttle
   import acq_pkg::*;
#(
   parameter int DEPTH      = 16,   // sizes the count port only
   parameter int BLOCK_SIZE = 8,
   parameter int FILL_LEVEL = 12
) (
   input  logic                   okClk,
   input  logic                   rst,
   input  logic [$clog2(DEPTH):0] count,
   output logic                   block_ready,
   output logic                   fill_trigger
);

   localparam int CW = $clog2(DEPTH) + 1;
   localparam logic [CW-1:0] block_lvl = CW'(BLOCK_SIZE);
   localparam logic [CW-1:0] fill_lvl  = CW'(FILL_LEVEL);

   logic above;     // count at or past the fill level
   logic above_q;

   assign above = (count >= fill_lvl);

   always_ff @(posedge okClk) begin
      if (rst) begin
         block_ready  <= 1'b0;
         fill_trigger <= 1'b0;
         above_q      <= 1'b0;
      end else begin
         block_ready  <= (count >= block_lvl);   // a whole block can be read
         above_q      <= above;
         fill_trigger <= above & ~above_q;       // once per upward crossing
      end
   end

endmodule

`default_nettype wire

// ==== logic/sample_fifo.sv ====
// ========================================
// single clock sample fifo, DEPTH a power of two
// writes when full are dropped and set a sticky overflow
// rd_data is valid one cycle after an accepted rd_en
// ========================================
`timescale 1ns/1ns
`default_nettype none

module sample_fifo
   import acq_pkg::*;
#(
   parameter int DEPTH = 16
) (
   input  logic                   okClk,
   input  logic                   rst,
   input  acq_cfg_t               cfg,
   input  logic                   word_wr,
   input  sample_word_u           word,
   input  logic                   rd_en,
   output logic [word_w-1:0]      rd_data,
   output logic                   rd_valid,
   output logic [$clog2(DEPTH):0] count,
   output logic                   overflow
);

   localparam int AW = $clog2(DEPTH);
   localparam logic [AW:0] full_lvl = (AW+1)'(DEPTH);

   logic [word_w-1:0] mem [DEPTH];
   logic [AW-1:0]     wr_ptr;
   logic [AW-1:0]     rd_ptr;
   logic              full;
   logic              empty;
   logic              do_wr;
   logic              do_rd;

   assign full  = (count == full_lvl);
   assign empty = (count == '0);
   assign do_wr = word_wr & ~full;
   assign do_rd = rd_en & ~empty;   // empty reads ignored

   // ========================================
   // pointers, occupancy, flags
   // ========================================
   always_ff @(posedge okClk) begin
      if (rst || cfg.soft_rst) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         count    <= '0;
         rd_valid <= 1'b0;
         overflow <= 1'b0;
      end else begin
         rd_valid <= do_rd;
         if (do_wr) wr_ptr <= wr_ptr + 1'b1;   // wraps at DEPTH
         if (do_rd) rd_ptr <= rd_ptr + 1'b1;
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // both or neither, level unchanged
         endcase
         if (word_wr && full) overflow <= 1'b1;
      end
   end

   // storage and read port
   always_ff @(posedge okClk) begin
      if (do_wr) mem[wr_ptr] <= word.raw;
      if (do_rd) rd_data <= mem[rd_ptr];
   end

endmodule

`default_nettype wire

// ==== logic/sample_tagger.sv ====
// ========================================
// edge detect, trigger qualify and pack one word per strobe
// adc_data arrives bit reversed from the board wiring
// word_wr follows adc_strobe by one cycle when capture is on
// ========================================
`timescale 1ns/1ns
`default_nettype none

module sample_tagger
   import acq_pkg::*;
(
   input  logic             okClk,
   input  logic             rst,
   input  acq_cfg_t         cfg,
   input  logic             manual_trig,
   input  logic             adc_strobe,
   input  logic [adc_w-1:0] adc_data,
   output logic             word_wr,
   output sample_word_u     word
);

   logic [adc_w-1:0] sample_fix;    // restored bit order
   logic [adc_w-1:0] prev_sample;
   logic             prev_valid;    // no edge on first sample
   logic             man_pend;
   logic             man_now;
   logic             rise;
   logic             fall;
   logic             do_wr;
   sample_word_u     next_word;

   // undo the board bit swap, adc bit 0 came in on the msb
   always_comb begin
      for (int i = 0; i < adc_w; i++) begin
         sample_fix[i] = adc_data[adc_w-1-i];
      end
   end

   // ========================================
   // edges and trigger bits
   // ========================================
   assign rise    = prev_valid && (prev_sample < cfg.threshold) && (sample_fix >= cfg.threshold);
   assign fall    = prev_valid && (prev_sample >= cfg.threshold) && (sample_fix < cfg.threshold);
   assign man_now = man_pend | manual_trig;   // pulse may coincide with a strobe
   assign do_wr   = adc_strobe & cfg.capture_en;

   always_comb begin
      next_word.fields.dac_value = cfg.dac_value;
      next_word.fields.sample    = sample_fix;
      next_word.fields.trig_fall = (fall & cfg.trig_en) | man_now;
      next_word.fields.trig_rise = (rise & cfg.trig_en) | man_now;
   end

   always_ff @(posedge okClk) begin
      if (rst || cfg.soft_rst) begin
         prev_valid <= 1'b0;
         man_pend   <= 1'b0;
         word_wr    <= 1'b0;
      end else begin
         word_wr <= do_wr;
         if (adc_strobe) prev_valid <= 1'b1;
         man_pend <= man_now & ~do_wr;   // consumed by the next word written
      end
   end

   // payload, qualified by prev_valid and word_wr
   always_ff @(posedge okClk) begin
      if (adc_strobe) prev_sample <= sample_fix;
      if (do_wr) word <= next_word;
   end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build the acquisition testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module acq_tb -f sim.f -Mdir obj_dir

# a failed run still reaches the search below
out=$(./obj_dir/Vacq_tb 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "sim passed"; then
   exit 0
fi
exit 1

// ==== sim.f ====
logic/acq_pkg.sv
logic/acq_regs.sv
logic/sample_tagger.sv
logic/sample_fifo.sv
logic/block_throttle.sv
logic/acq_top.sv
test/acq_props.sv
test/acq_tb.sv

// ==== test/acq_props.sv ====
// ========================================
// fifo checks, bound into every sample_fifo
// ========================================
`timescale 1ns/1ns
`default_nettype none

module fifo_props
   import acq_pkg::*;
#(
   parameter int DEPTH = 16
) (
   input logic                   okClk,
   input logic                   rst,
   input acq_cfg_t               cfg,
   input logic                   rd_en,
   input logic                   rd_valid,
   input logic [$clog2(DEPTH):0] count,
   input logic                   overflow
);

   localparam int CW = $clog2(DEPTH) + 1;

   // occupancy bounded by the buffer
   assert property (@(posedge okClk) disable iff (rst) count <= CW'(DEPTH))
      else $error("fifo count above DEPTH");

   assert property (@(posedge okClk) disable iff (rst) rd_valid |-> $past(rd_en))
      else $error("rd_valid without a read request");

   // sticky until rst or soft reset
   assert property (@(posedge okClk) disable iff (rst) (overflow && !cfg.soft_rst) |=> overflow)
      else $error("overflow cleared without a reset");

endmodule

bind sample_fifo fifo_props #(.DEPTH(DEPTH)) u_props (
   .okClk    (okClk),
   .rst      (rst),
   .cfg      (cfg),
   .rd_en    (rd_en),
   .rd_valid (rd_valid),
   .count    (count),
   .overflow (overflow)
);

`default_nettype wire

// ==== test/acq_tb.sv ====
// ========================================
// self checking testbench for acq_top
// DEPTH 16, BLOCK_SIZE 8, FILL_LEVEL 12
// host reads never overlap sample strobes
// ========================================
`timescale 1ns/1ns
`default_nettype none

module acq_tb
   import acq_pkg::*;
();

   localparam int DEPTH      = 16;
   localparam int BLOCK_SIZE = 8;
   localparam int FILL_LEVEL = 12;

   logic                   okClk = 1'b0;
   logic                   rst;
   logic                   reg_wr;
   logic [7:0]             reg_addr;
   logic [word_w-1:0]      reg_wdata;
   logic                   adc_strobe;
   logic [adc_w-1:0]       adc_data;
   logic                   rd_en;
   logic [word_w-1:0]      rd_data;
   logic                   rd_valid;
   logic [1:0]             adc_mux;
   logic [$clog2(DEPTH):0] fill_count;
   logic                   overflow;
   logic                   block_ready;
   logic                   fill_trigger;

   // reference model state
   logic [word_w-1:0] exp_q [$];
   acq_cfg_t          m_cfg;      // mirror of the host registers
   logic [adc_w-1:0]  m_prev;
   logic              m_prev_v;
   logic              m_man;      // manual trigger pending
   int                errors;
   int                timeouts;
   int                fill_pulses;
   int                pulse_base;
   integer            seed;

   acq_top #(
      .DEPTH      (DEPTH),
      .BLOCK_SIZE (BLOCK_SIZE),
      .FILL_LEVEL (FILL_LEVEL)
   ) DUT (
      .okClk        (okClk),
      .rst          (rst),
      .reg_wr       (reg_wr),
      .reg_addr     (reg_addr),
      .reg_wdata    (reg_wdata),
      .adc_strobe   (adc_strobe),
      .adc_data     (adc_data),
      .rd_en        (rd_en),
      .rd_data      (rd_data),
      .rd_valid     (rd_valid),
      .adc_mux      (adc_mux),
      .fill_count   (fill_count),
      .overflow     (overflow),
      .block_ready  (block_ready),
      .fill_trigger (fill_trigger)
   );

   always #5 okClk = ~okClk;

   // ========================================
   // reference model
   // ========================================
   function automatic logic [word_w-1:0] expected_word(
      input logic [adc_w-1:0] prev,
      input logic             prev_v,
      input logic [adc_w-1:0] cur,
      input acq_cfg_t         cfg,
      input logic             man
   );
      sample_word_u w;
      logic         rise;
      logic         fall;
      rise = prev_v && (prev < cfg.threshold) && (cur >= cfg.threshold);
      fall = prev_v && (prev >= cfg.threshold) && (cur < cfg.threshold);
      w.fields.dac_value = cfg.dac_value;
      w.fields.sample    = cur;
      w.fields.trig_rise = (rise && cfg.trig_en) || man;
      w.fields.trig_fall = (fall && cfg.trig_en) || man;
      return w.raw;
   endfunction

   task automatic check_bit(input string name, input logic got, input logic exp);
      assert (got === exp) else begin
         errors++;
         $display("[FAIL] %s exp %h got %h", name, exp, got);
      end
   endtask

   // one host write, mirrored into the model once it has landed
   task automatic reg_write(input logic [7:0] addr, input logic [word_w-1:0] data);
      @(posedge okClk);
      #1;
      reg_wr    = 1'b1;
      reg_addr  = addr;
      reg_wdata = data;
      @(posedge okClk);
      #1;
      reg_wr = 1'b0;
      case (addr)
         addr_ctrl: begin
            m_cfg.trig_en    = data[ctrl_trig_en_bit];
            m_cfg.capture_en = data[ctrl_capture_bit];
            if (data[ctrl_soft_rst_bit]) begin
               m_prev_v = 1'b0;   // fifo and history flushed
               m_man    = 1'b0;
               exp_q.delete();
            end
         end
         addr_thresh: m_cfg.threshold = data[adc_w-1:0];
         addr_dac:    m_cfg.dac_value = data[dac_w-1:0];
         addr_trig:   if (data[trig_manual_bit]) m_man = 1'b1;
         default: ;
      endcase
   endtask

   task automatic set_ctrl(input logic trig, input logic cap, input logic srst);
      logic [word_w-1:0] d;
      d = '0;
      d[ctrl_trig_en_bit]  = trig;
      d[ctrl_capture_bit]  = cap;
      d[ctrl_soft_rst_bit] = srst;
      reg_write(addr_ctrl, d);
   endtask

   task automatic soft_reset();
      set_ctrl(m_cfg.trig_en, m_cfg.capture_en, 1'b1);
      set_ctrl(m_cfg.trig_en, m_cfg.capture_en, 1'b0);
   endtask

   task automatic strobe_sample(input logic [adc_w-1:0] val);
      @(posedge okClk);
      #1;
      adc_strobe = 1'b1;
      adc_data   = {<<{val}};   // board wiring swaps bit order
      if (m_cfg.capture_en) begin
         if (exp_q.size() < DEPTH) begin
            exp_q.push_back(expected_word(m_prev, m_prev_v, val, m_cfg, m_man));
         end
         m_man = 1'b0;
      end
      m_prev   = val;
      m_prev_v = 1'b1;
      @(posedge okClk);
      #1;
      adc_strobe = 1'b0;
   endtask

   task automatic read_words(input int n);
      int target;
      int t;
      target = exp_q.size() - n;
      @(posedge okClk);
      #1;
      rd_en = 1'b1;
      repeat (n) @(posedge okClk);
      #1;
      rd_en = 1'b0;
      for (t = 0; t < 20 && exp_q.size() != target; t++) @(negedge okClk);
      assert (exp_q.size() == target) else begin
         timeouts++;
         $display("timeout while reading, %0d words never came back", exp_q.size() - target);
      end
   endtask

   // fill level settles, then block_ready one cycle later
   task automatic wait_level(input int n);
      int t;
      for (t = 0; t < 20 && int'(fill_count) != n; t++) @(negedge okClk);
      assert (int'(fill_count) == n) else begin
         timeouts++;
         $display("timeout, fill_count stayed at %0d instead of reaching %0d", fill_count, n);
      end
      @(negedge okClk);
      check_bit("block_ready", block_ready, n >= BLOCK_SIZE);
   endtask

   task automatic check_pulses(input int exp_n);
      repeat (2) @(posedge okClk);
      assert (fill_pulses == exp_n) else begin
         errors++;
         $display("[FAIL] fill_trigger pulses exp %h got %h", exp_n, fill_pulses);
      end
   endtask

   // ========================================
   // compare process
   // ========================================
   task automatic watch_outputs();
      forever begin
         @(negedge okClk);
         if (fill_trigger) fill_pulses++;
         if (rd_valid) begin
            assert (exp_q.size() > 0) else begin
               errors++;
               $display("rd_valid came with no word left to expect");
            end
            if (exp_q.size() > 0) begin
               assert (rd_data == exp_q[0]) else begin
                  errors++;
                  $display("[FAIL] rd_data exp %h got %h", exp_q[0], rd_data);
               end
               void'(exp_q.pop_front());
            end
         end
      end
   endtask

   initial begin
      rst         = 1'b1;
      reg_wr      = 1'b0;
      reg_addr    = '0;
      reg_wdata   = '0;
      adc_strobe  = 1'b0;
      adc_data    = '0;
      rd_en       = 1'b0;
      m_cfg       = '0;
      m_prev      = '0;
      m_prev_v    = 1'b0;
      m_man       = 1'b0;
      errors      = 0;
      timeouts    = 0;
      fill_pulses = 0;
      seed        = 32'h186;
      repeat (8) @(posedge okClk);
      #1;
      rst = 1'b0;
      fork
         watch_outputs();
      join_none
      check_bit("rd_valid", rd_valid, 1'b0);
      check_bit("block_ready", block_ready, 1'b0);
      check_bit("fill_trigger", fill_trigger, 1'b0);
      check_bit("overflow", overflow, 1'b0);

      // plain capture, no trigger bits
      reg_write(addr_dac, 32'h0000_a5c3);
      reg_write(addr_thresh, 32'h0000_1000);
      set_ctrl(1'b0, 1'b1, 1'b0);
      repeat (10) strobe_sample(adc_w'($random(seed)));
      wait_level(10);
      read_words(exp_q.size());

      // threshold edges, first sample after soft reset has no edge
      set_ctrl(1'b1, 1'b1, 1'b0);
      strobe_sample(14'h0010);
      soft_reset();
      wait_level(0);
      strobe_sample(14'h1800);
      strobe_sample(14'h0400);
      strobe_sample(14'h2000);
      strobe_sample(14'h1000);   // at threshold from above, no edge
      strobe_sample(14'h0fff);
      strobe_sample(14'h1000);
      repeat (4) strobe_sample(adc_w'($random(seed)));
      wait_level(10);
      read_words(exp_q.size());

      // manual trigger, trig_en off then on
      set_ctrl(1'b0, 1'b1, 1'b0);
      reg_write(addr_trig, 32'h0000_0002);
      strobe_sample(14'h0100);
      strobe_sample(14'h3000);
      set_ctrl(1'b1, 1'b1, 1'b0);
      reg_write(addr_trig, 32'h0000_0002);
      strobe_sample(14'h0100);
      strobe_sample(14'h0200);
      wait_level(4);
      read_words(exp_q.size());

      // capture off, mux register
      set_ctrl(1'b0, 1'b0, 1'b0);
      repeat (4) strobe_sample(adc_w'($random(seed)));
      repeat (4) @(negedge okClk);
      assert (fill_count == '0) else begin
         errors++;
         $display("[FAIL] fill_count exp 00 got %h", fill_count);
      end
      reg_write(addr_adcmux, 32'h0000_0002);
      assert (adc_mux == 2'h2) else begin
         errors++;
         $display("[FAIL] adc_mux exp 2 got %h", adc_mux);
      end

      // block_ready and fill level crossings
      set_ctrl(1'b0, 1'b1, 1'b0);
      pulse_base = fill_pulses;
      repeat (BLOCK_SIZE) strobe_sample(adc_w'($random(seed)));
      wait_level(BLOCK_SIZE);
      repeat (FILL_LEVEL - BLOCK_SIZE) strobe_sample(adc_w'($random(seed)));
      wait_level(FILL_LEVEL);
      check_pulses(pulse_base + 1);
      repeat (2) strobe_sample(adc_w'($random(seed)));
      wait_level(FILL_LEVEL + 2);
      read_words(4);
      wait_level(FILL_LEVEL - 2);
      check_pulses(pulse_base + 1);
      repeat (2) strobe_sample(adc_w'($random(seed)));
      wait_level(FILL_LEVEL);
      check_pulses(pulse_base + 2);
      read_words(exp_q.size());
      wait_level(0);

      // overflow keeps the first DEPTH words, soft reset clears it
      repeat (DEPTH + 3) strobe_sample(adc_w'($random(seed)));
      wait_level(DEPTH);
      check_bit("overflow", overflow, 1'b1);
      read_words(exp_q.size());
      wait_level(0);
      check_bit("overflow", overflow, 1'b1);
      repeat (5) strobe_sample(adc_w'($random(seed)));
      wait_level(5);
      soft_reset();
      wait_level(0);
      check_bit("overflow", overflow, 1'b0);

      repeat (4) @(posedge okClk);
      $display("errors %0d, timeouts %0d", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

`default_nettype wire
